/* rtl/fetch_pkg.sv */
package fetch_pkg;

  // core widths
  localparam int XLEN   = 64;  // address and memory beat width
  localparam int INST_W = 32;  // one rv instruction

  typedef logic [XLEN-1:0]   pc_t;        // byte address of an instruction
  typedef logic [INST_W-1:0] inst_t;
  typedef logic [XLEN-1:0]   mem_word_t;  // one beat, two instructions

  localparam pc_t RESET_PC = 64'h8000_0000;  // first fetch after reset

  // cache geometry
  localparam int LINE_BEATS = 4;                   // 32 byte line
  localparam int BEAT_W     = $clog2(LINE_BEATS);  // beat select within a line
  localparam int IC_SETS    = 16;
  localparam int IDX_W      = $clog2(IC_SETS);
  localparam int OFF_W      = 5;                   // byte offset in a line
  localparam int TAG_W      = XLEN - IDX_W - OFF_W;

  typedef logic [LINE_BEATS*XLEN-1:0] line_t;  // beat 0 in the low bits
  typedef logic [TAG_W-1:0]           tag_t;
  typedef logic [IDX_W-1:0]           idx_t;
  typedef logic [BEAT_W:0]            beat_cnt_t;  // counts up to LINE_BEATS

  // credit pools
  localparam int DEC_CREDITS = 4;  // decode input buffer depth
  localparam int MEM_CREDITS = 2;  // memory request slots
  localparam int DEC_CNT_W   = $clog2(DEC_CREDITS + 1);
  localparam int MEM_CNT_W   = $clog2(MEM_CREDITS + 1);

  typedef logic [DEC_CNT_W-1:0] dec_cnt_t;
  typedef logic [MEM_CNT_W-1:0] mem_cnt_t;

  // refill sequencer
  typedef enum logic [1:0] {
    IDLE,  // no line pending
    REQ,   // issuing beat reads
    WAIT,  // all reads out, collecting data
    DONE   // line complete, fill pulse
  } refill_state_e;

  // cache control
  typedef enum logic [1:0] {
    RUN,   // lookups flowing
    MISS,  // request the line
    FILL   // wait for the line
  } icache_state_e;

endpackage

/* rtl/pc_gen.sv */
`timescale 1ns/1ps

module pc_gen (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           redirect_i,     // from execute
  input  fetch_pkg::pc_t redirect_pc_i,
  input  logic           dec_credit_i,   // one pulse per consumed instruction
  input  logic           stall_i,        // cache busy with a miss
  input  logic           hit_valid_i,    // cache presenting an instruction
  output logic           lookup_valid_o,
  output fetch_pkg::pc_t lookup_pc_o,
  output logic           kill_o
);

  fetch_pkg::pc_t      fetch_pc_q;  // next pc to look up
  fetch_pkg::dec_cnt_t credit_q;    // free decode slots, reserved at issue
  fetch_pkg::dec_cnt_t inflight_q;  // issued, not yet presented
  fetch_pkg::dec_cnt_t refund;
  logic                issue;

  // no issue in the redirect cycle, target goes out next cycle
  assign issue = ~redirect_i & ~stall_i & (credit_q != '0);

  // killed lookups never reach decode, so hand their slots back
  assign refund = redirect_i ? inflight_q : '0;

  assign lookup_valid_o = issue;
  assign lookup_pc_o    = fetch_pc_q;
  assign kill_o         = redirect_i;  // flush everything in the cache pipe

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_pc_q <= fetch_pkg::RESET_PC;
    end else if (redirect_i) begin
      fetch_pc_q <= redirect_pc_i;  // held through a stall
    end else if (issue) begin
      fetch_pc_q <= fetch_pc_q + fetch_pkg::pc_t'(4);  // static pc+4
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_q   <= fetch_pkg::dec_cnt_t'(fetch_pkg::DEC_CREDITS);
      inflight_q <= '0;
    end else begin
      credit_q <= credit_q - fetch_pkg::dec_cnt_t'(issue)
                + fetch_pkg::dec_cnt_t'(dec_credit_i) + refund;
      if (redirect_i) begin
        inflight_q <= '0;
      end else begin
        inflight_q <= inflight_q + fetch_pkg::dec_cnt_t'(issue)
                    - fetch_pkg::dec_cnt_t'(hit_valid_i);
      end
    end
  end

  // redirect targets come from execute, so alignment is checked at issue
  a_lookup_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    lookup_valid_o |-> (lookup_pc_o[1:0] == 2'b00))
    else $error("lookup pc not 4-byte aligned");

  a_dec_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
    credit_q <= fetch_pkg::DEC_CREDITS)
    else $error("decode credit count above maximum");

  // cache must never present something this block did not issue
  a_hit_has_lookup: assert property (@(posedge clk) disable iff (!rst_n)
    hit_valid_i |-> (inflight_q != '0))
    else $error("cache output with no lookup in flight");

endmodule

/* rtl/icache.sv */
`timescale 1ns/1ps

module icache (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             lookup_valid_i,
  input  fetch_pkg::pc_t   lookup_pc_i,
  input  logic             kill_i,         // redirect, drop the current result
  output logic             inst_valid_o,
  output fetch_pkg::inst_t inst_o,
  output fetch_pkg::pc_t   pc_o,
  output logic             stall_o,
  output logic             miss_req_o,
  output fetch_pkg::pc_t   miss_addr_o,    // line aligned
  input  logic             fill_valid_i,   // single pulse from refill
  input  fetch_pkg::line_t fill_line_i
);

  fetch_pkg::icache_state_e state_q;
  fetch_pkg::icache_state_e state_d;

  // registered lookup stage
  logic           s1_valid_q;
  fetch_pkg::pc_t s1_pc_q;

  // tag/data arrays, valid bits are the only part that is reset
  logic [fetch_pkg::IC_SETS-1:0] valid_q;
  fetch_pkg::tag_t               tag_q  [fetch_pkg::IC_SETS];
  fetch_pkg::line_t              data_q [fetch_pkg::IC_SETS];

  fetch_pkg::idx_t             s1_idx;
  fetch_pkg::tag_t             s1_tag;
  logic [fetch_pkg::OFF_W-3:0] s1_word;  // instruction within the line
  fetch_pkg::line_t            s1_line;
  logic                        hit;
  logic                        miss_now;
  logic                        s1_advance;

  assign s1_idx  = s1_pc_q[fetch_pkg::OFF_W +: fetch_pkg::IDX_W];
  assign s1_tag  = s1_pc_q[fetch_pkg::XLEN-1 -: fetch_pkg::TAG_W];
  assign s1_word = s1_pc_q[fetch_pkg::OFF_W-1:2];
  assign s1_line = data_q[s1_idx];

  assign hit = valid_q[s1_idx] & (tag_q[s1_idx] == s1_tag);

  // a killed lookup never starts a refill
  assign miss_now = (state_q == fetch_pkg::RUN) & s1_valid_q & ~hit & ~kill_i;

  // stage moves only in RUN without a fresh miss, else the pc is held for replay
  assign s1_advance = (state_q == fetch_pkg::RUN) & ~miss_now;

  assign inst_valid_o = (state_q == fetch_pkg::RUN) & s1_valid_q & hit & ~kill_i;
  assign inst_o       = s1_line[s1_word*fetch_pkg::INST_W +: fetch_pkg::INST_W];
  assign pc_o         = s1_pc_q;

  assign stall_o     = (state_q != fetch_pkg::RUN) | miss_now;  // high from N+1
  assign miss_req_o  = (state_q == fetch_pkg::MISS);
  assign miss_addr_o = {s1_pc_q[fetch_pkg::XLEN-1:fetch_pkg::OFF_W],
                        {fetch_pkg::OFF_W{1'b0}}};

  always_comb begin
    state_d = state_q;
    case (state_q)
      fetch_pkg::RUN: begin
        if (miss_now) begin
          state_d = fetch_pkg::MISS;
        end
      end
      fetch_pkg::MISS: begin
        state_d = fetch_pkg::FILL;  // refill is idle here, takes it at once
      end
      fetch_pkg::FILL: begin
        if (fill_valid_i) begin
          state_d = fetch_pkg::RUN;  // replay of the held pc next cycle
        end
      end
      default: begin
        state_d = fetch_pkg::RUN;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= fetch_pkg::RUN;
      s1_valid_q <= 1'b0;
      valid_q    <= '0;
    end else begin
      state_q <= state_d;
      if (s1_advance) begin
        s1_valid_q <= lookup_valid_i & ~kill_i;
      end else if (kill_i) begin
        s1_valid_q <= 1'b0;  // line still fills, replay shows nothing
      end
      if (fill_valid_i) begin
        valid_q[s1_idx] <= 1'b1;
      end
    end
  end

  // lookup pc, kept through MISS and FILL as the fill index
  always_ff @(posedge clk) begin
    if (s1_advance && lookup_valid_i) begin
      s1_pc_q <= lookup_pc_i;
    end
  end

  always_ff @(posedge clk) begin
    if (fill_valid_i) begin
      tag_q[s1_idx]  <= s1_tag;
      data_q[s1_idx] <= fill_line_i;
    end
  end

  // refill must only answer a miss this cache is waiting on
  a_fill_in_fill: assert property (@(posedge clk) disable iff (!rst_n)
    fill_valid_i |-> (state_q == fetch_pkg::FILL))
    else $error("line fill outside FILL state");

endmodule

/* rtl/refill_ctrl.sv */
`timescale 1ns/1ps

module refill_ctrl (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 miss_req_i,
  input  fetch_pkg::pc_t       miss_addr_i,     // line aligned
  output logic                 fill_valid_o,
  output fetch_pkg::line_t     fill_line_o,
  output logic                 mem_req_valid_o,
  output fetch_pkg::pc_t       mem_req_addr_o,  // 8 byte aligned beat address
  input  logic                 mem_credit_i,    // one pulse per freed slot
  input  logic                 mem_rsp_valid_i,
  input  fetch_pkg::mem_word_t mem_rsp_data_i
);

  fetch_pkg::refill_state_e state_q;
  fetch_pkg::refill_state_e state_d;

  logic [fetch_pkg::XLEN-fetch_pkg::OFF_W-1:0] line_addr_q;  // tag and index
  fetch_pkg::beat_cnt_t req_cnt_q;  // beats requested
  fetch_pkg::beat_cnt_t rsp_cnt_q;  // beats received
  fetch_pkg::mem_cnt_t  credit_q;   // free memory slots
  fetch_pkg::line_t     line_q;

  logic issue;
  logic last_req;
  logic rsp_take;
  logic last_rsp;

  assign issue    = (state_q == fetch_pkg::REQ) & (credit_q != '0);  // else hold in REQ
  assign last_req = issue
                  & (req_cnt_q == fetch_pkg::beat_cnt_t'(fetch_pkg::LINE_BEATS - 1));

  // responses can overlap the request phase
  assign rsp_take = mem_rsp_valid_i
                  & ((state_q == fetch_pkg::REQ) | (state_q == fetch_pkg::WAIT));
  assign last_rsp = rsp_take
                  & (rsp_cnt_q == fetch_pkg::beat_cnt_t'(fetch_pkg::LINE_BEATS - 1));

  assign mem_req_valid_o = issue;
  assign mem_req_addr_o  = {line_addr_q, req_cnt_q[fetch_pkg::BEAT_W-1:0],
                            {(fetch_pkg::OFF_W - fetch_pkg::BEAT_W){1'b0}}};

  assign fill_valid_o = (state_q == fetch_pkg::DONE);  // one cycle only
  assign fill_line_o  = line_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      fetch_pkg::IDLE: if (miss_req_i) state_d = fetch_pkg::REQ;
      fetch_pkg::REQ:  if (last_req) state_d = fetch_pkg::WAIT;
      fetch_pkg::WAIT: if (last_rsp) state_d = fetch_pkg::DONE;
      default:         state_d = fetch_pkg::IDLE;  // DONE lasts one cycle
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= fetch_pkg::IDLE;
      req_cnt_q <= '0;
      rsp_cnt_q <= '0;
      credit_q  <= fetch_pkg::mem_cnt_t'(fetch_pkg::MEM_CREDITS);
    end else begin
      state_q  <= state_d;
      credit_q <= credit_q - fetch_pkg::mem_cnt_t'(issue)
                + fetch_pkg::mem_cnt_t'(mem_credit_i);
      if ((state_q == fetch_pkg::IDLE) && miss_req_i) begin
        req_cnt_q <= '0;  // new line
        rsp_cnt_q <= '0;
      end else begin
        if (issue) begin
          req_cnt_q <= req_cnt_q + 1'b1;
        end
        if (rsp_take) begin
          rsp_cnt_q <= rsp_cnt_q + 1'b1;
        end
      end
    end
  end

  // line base and data, payload only
  always_ff @(posedge clk) begin
    if ((state_q == fetch_pkg::IDLE) && miss_req_i) begin
      line_addr_q <= miss_addr_i[fetch_pkg::XLEN-1:fetch_pkg::OFF_W];
    end
    if (rsp_take) begin
      // in order return, so arrival count is the beat number
      line_q[rsp_cnt_q[fetch_pkg::BEAT_W-1:0]*fetch_pkg::XLEN +: fetch_pkg::XLEN]
        <= mem_rsp_data_i;
    end
  end

  a_mem_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
    credit_q <= fetch_pkg::MEM_CREDITS)
    else $error("memory credit count above maximum");

  // a response must match a request still outstanding on the port
  a_rsp_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    mem_rsp_valid_i |-> (rsp_take && (rsp_cnt_q < req_cnt_q)))
    else $error("memory response with no request outstanding");

  // cache holds off new misses until the previous fill is written
  a_miss_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    miss_req_i |-> (state_q == fetch_pkg::IDLE))
    else $error("miss request while refill busy");

endmodule

/* rtl/if_stage.sv */
`timescale 1ns/1ps

module if_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  // redirect from execute
  input  logic                 redirect_i,
  input  fetch_pkg::pc_t       redirect_pc_i,
  // decode link
  input  logic                 dec_credit_i,
  output logic                 inst_valid_o,
  output fetch_pkg::inst_t     inst_o,
  output fetch_pkg::pc_t       pc_o,
  // memory read port
  output logic                 mem_req_valid_o,
  output fetch_pkg::pc_t       mem_req_addr_o,
  input  logic                 mem_credit_i,
  input  logic                 mem_rsp_valid_i,
  input  fetch_pkg::mem_word_t mem_rsp_data_i
);

  // pc_gen to icache
  logic             lookup_valid;
  fetch_pkg::pc_t   lookup_pc;
  logic             kill;
  // icache back to pc_gen and out to decode
  logic             hit_valid;
  fetch_pkg::inst_t hit_inst;
  fetch_pkg::pc_t   hit_pc;
  logic             stall;
  // icache to refill
  logic             miss_req;
  fetch_pkg::pc_t   miss_addr;
  logic             fill_valid;
  fetch_pkg::line_t fill_line;

  // hit goes straight to decode, same cycle
  assign inst_valid_o = hit_valid;
  assign inst_o       = hit_inst;
  assign pc_o         = hit_pc;

  pc_gen i_pc_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .dec_credit_i  (dec_credit_i),
    .stall_i       (stall),
    .hit_valid_i   (hit_valid),     // closes the in-flight count
    .lookup_valid_o(lookup_valid),
    .lookup_pc_o   (lookup_pc),
    .kill_o        (kill)
  );

  icache i_icache (
    .clk           (clk),
    .rst_n         (rst_n),
    .lookup_valid_i(lookup_valid),
    .lookup_pc_i   (lookup_pc),
    .kill_i        (kill),
    .inst_valid_o  (hit_valid),
    .inst_o        (hit_inst),
    .pc_o          (hit_pc),
    .stall_o       (stall),
    .miss_req_o    (miss_req),
    .miss_addr_o   (miss_addr),
    .fill_valid_i  (fill_valid),
    .fill_line_i   (fill_line)
  );

  refill_ctrl i_refill_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .miss_req_i     (miss_req),
    .miss_addr_i    (miss_addr),
    .fill_valid_o   (fill_valid),
    .fill_line_o    (fill_line),
    .mem_req_valid_o(mem_req_valid_o),
    .mem_req_addr_o (mem_req_addr_o),
    .mem_credit_i   (mem_credit_i),
    .mem_rsp_valid_i(mem_rsp_valid_i),  // always accepted
    .mem_rsp_data_i (mem_rsp_data_i)
  );

endmodule

/* dv/mem_model.sv */
`timescale 1ns/1ps

module mem_model (
  input  logic                 clk,
  input  logic                 req_valid_i,
  input  fetch_pkg::pc_t       req_addr_i,    // 8 byte aligned beat address
  input  int                   credit_gap_i,  // idle cycles between credit pulses
  output logic                 credit_o,
  output logic                 rsp_valid_o,
  output fetch_pkg::mem_word_t rsp_data_o
);

  integer         seed;
  longint         cycle;
  fetch_pkg::pc_t addr_q [$];   // accepted requests, oldest first
  longint         ready_q [$];  // cycle each response may leave
  int             owed;         // credits not yet handed back
  int             gap_cnt;

  // instruction at A is ~A[31:0], the word at A+4 sits in the upper half
  function automatic fetch_pkg::mem_word_t beat_data(input fetch_pkg::pc_t a);
    fetch_pkg::pc_t hi;
    hi = a + fetch_pkg::pc_t'(4);
    return {~hi[31:0], ~a[31:0]};
  endfunction

  // response and credit driver, 2 ns after the edge
  initial begin
    seed        = 2;
    cycle       = 0;
    owed        = 0;
    gap_cnt     = 0;
    credit_o    = 1'b0;
    rsp_valid_o = 1'b0;
    rsp_data_o  = '0;
    forever begin
      @(posedge clk);
      cycle = cycle + 1;
      #2;
      rsp_valid_o = 1'b0;
      if (addr_q.size() != 0 && ready_q[0] <= cycle) begin
        rsp_valid_o = 1'b1;  // head only, keeps order
        rsp_data_o  = beat_data(addr_q.pop_front());
        void'(ready_q.pop_front());
        owed = owed + 1;
      end
      credit_o = 1'b0;
      if (gap_cnt > 0) begin
        gap_cnt = gap_cnt - 1;  // throttled
      end else if (owed > 0) begin
        credit_o = 1'b1;
        owed     = owed - 1;
        gap_cnt  = credit_gap_i;
      end
    end
  end

  // requests are stable mid cycle
  always @(negedge clk) begin
    int lat;
    if (req_valid_i) begin
      lat = 1 + int'($unsigned($random(seed)) % 6);  // 1 to 6 cycles
      addr_q.push_back(req_addr_i);
      ready_q.push_back(cycle + lat);
    end
  end

endmodule

/* dv/tb_if_stage.sv */
`timescale 1ns/1ps

module tb_if_stage;

  localparam int FETCH_TOTAL = 1 + 40 + 12 + 24 + 24 + 12;  // outputs awaited over all tests
  localparam int WATCHDOG_CYCLES = 200 * FETCH_TOTAL;
  localparam int HOLD_CYCLES = 30;
  localparam int STREAM_LINES = 5;  // cold lines crossed by the sequential stream
  localparam fetch_pkg::pc_t TGT_HIT   = 64'h8000_0400;
  localparam fetch_pkg::pc_t TGT_MISS  = 64'h8000_0800;
  localparam fetch_pkg::pc_t TGT_AFTER = 64'h8000_0c00;
  localparam fetch_pkg::pc_t TGT_SLOW  = 64'h8000_2000;
  localparam fetch_pkg::pc_t LINE_A    = 64'h8000_1000;  // set 0

  logic                 clk;
  logic                 rst_n;
  logic                 redirect;
  fetch_pkg::pc_t       redirect_pc;
  logic                 dec_credit;
  logic                 inst_valid;
  fetch_pkg::inst_t     inst;
  fetch_pkg::pc_t       pc;
  logic                 mem_req_valid;
  fetch_pkg::pc_t       mem_req_addr;
  logic                 mem_credit;
  logic                 mem_rsp_valid;
  fetch_pkg::mem_word_t mem_rsp_data;

  // decode side model
  fetch_pkg::pc_t   exp_pc = fetch_pkg::RESET_PC;
  fetch_pkg::pc_t   last_pc = '0;
  int               recv_count = 0;
  int               owed_credits = 0;  // outputs not yet credited back
  logic             hold_credits = 1'b0;
  // memory side bookkeeping
  int               mem_avail = fetch_pkg::MEM_CREDITS;
  int               req_count = 0;
  int               mem_gap = 0;
  fetch_pkg::pc_t   watch_base = '1;  // beat 0 address of a watched line
  int               watch_hits = 0;

  if_stage i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .redirect_i     (redirect),
    .redirect_pc_i  (redirect_pc),
    .dec_credit_i   (dec_credit),
    .inst_valid_o   (inst_valid),
    .inst_o         (inst),
    .pc_o           (pc),
    .mem_req_valid_o(mem_req_valid),
    .mem_req_addr_o (mem_req_addr),
    .mem_credit_i   (mem_credit),
    .mem_rsp_valid_i(mem_rsp_valid),
    .mem_rsp_data_i (mem_rsp_data)
  );

  mem_model i_mem (
    .clk         (clk),
    .req_valid_i (mem_req_valid),
    .req_addr_i  (mem_req_addr),
    .credit_gap_i(mem_gap),
    .credit_o    (mem_credit),
    .rsp_valid_o (mem_rsp_valid),
    .rsp_data_o  (mem_rsp_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic fetch_pkg::inst_t expected_inst(input fetch_pkg::pc_t a);
    return ~a[31:0];
  endfunction

  task automatic end_with_failure();
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_pc(input string name, input fetch_pkg::pc_t act,
                          input fetch_pkg::pc_t exp);
    if (act !== exp) begin
      $display("FAIL %s: got 0x%h, expected 0x%h", name, act, exp);
      end_with_failure();
    end
  endtask

  task automatic check_inst(input string name, input fetch_pkg::inst_t act,
                            input fetch_pkg::inst_t exp);
    if (act !== exp) begin
      $display("FAIL %s: got 0x%h, expected 0x%h", name, act, exp);
      end_with_failure();
    end
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the fetch stream stopped before all tests finished");
    end_with_failure();
  end

  // monitor, outputs are stable at the falling edge
  always @(negedge clk) begin
    if (!rst_n) begin
      if (inst_valid !== 1'b0 || mem_req_valid !== 1'b0) begin
        $display("an output valid was high during reset");
        end_with_failure();
      end
    end else begin
      if (redirect && inst_valid) begin
        $display("instruction presented in the redirect cycle");
        end_with_failure();
      end
      if (inst_valid) begin
        check_pc("pc_o", pc, exp_pc);
        check_inst("inst_o", inst, expected_inst(exp_pc));
        last_pc      = pc;
        exp_pc       = exp_pc + fetch_pkg::pc_t'(4);
        recv_count   = recv_count + 1;
        owed_credits = owed_credits + 1;
        if (owed_credits > fetch_pkg::DEC_CREDITS) begin
          $display("more instructions outstanding at decode than it has slots");
          end_with_failure();
        end
      end
      if (mem_req_valid) begin
        if (mem_avail == 0) begin
          $display("memory request issued with no memory credit left");
          end_with_failure();
        end
        mem_avail = mem_avail - 1;
        req_count = req_count + 1;
        if (mem_req_addr == watch_base) watch_hits = watch_hits + 1;
      end
      if (mem_credit) mem_avail = mem_avail + 1;
    end
  end

  // decode hands back one credit per cycle unless held
  initial begin
    dec_credit = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      if (rst_n && !hold_credits && owed_credits > 0) begin
        dec_credit   = 1'b1;
        owed_credits = owed_credits - 1;
      end else begin
        dec_credit = 1'b0;
      end
    end
  end

  task automatic wait_outputs(input int n);
    int target;
    target = recv_count + n;
    while (recv_count < target) @(posedge clk);
  endtask

  task automatic pulse_redirect(input fetch_pkg::pc_t target);
    @(posedge clk);
    #2;
    redirect    = 1'b1;
    redirect_pc = target;
    exp_pc      = target;  // next valid output must carry the target
    @(posedge clk);
    #2;
    redirect = 1'b0;
  endtask

  task automatic test_reset_first_fetch();
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    wait_outputs(1);  // monitor expects RESET_PC first
  endtask

  task automatic test_sequential_stream();
    int reqs_before;
    reqs_before = req_count;
    wait_outputs(40);  // five cold lines, hits inside each
    // one refill per line, hits must not reach memory
    if (req_count - reqs_before != STREAM_LINES * fetch_pkg::LINE_BEATS) begin
      $display("sequential stream made %0d beat reads, expected %0d",
               req_count - reqs_before, STREAM_LINES * fetch_pkg::LINE_BEATS);
      end_with_failure();
    end
  endtask

  task automatic test_decode_backpressure();
    @(negedge clk);
    hold_credits = 1'b1;
    repeat (HOLD_CYCLES) @(posedge clk);
    // all slots spent by now, monitor flags anything beyond
    if (owed_credits != fetch_pkg::DEC_CREDITS) begin
      $display("decode slots were not all used while credits were held");
      end_with_failure();
    end
    @(negedge clk);
    hold_credits = 1'b0;
    wait_outputs(12);  // monitor catches any gap or repeat
  endtask

  task automatic test_redirect();
    wait_outputs(1);
    while (last_pc[4:2] != 3'd2) wait_outputs(1);  // mid line, hits follow
    pulse_redirect(TGT_HIT);
    wait_outputs(8);
    watch_base = TGT_MISS;
    watch_hits = 0;
    pulse_redirect(TGT_MISS);
    while (watch_hits == 0) @(posedge clk);  // refill of the target under way
    pulse_redirect(TGT_AFTER);
    wait_outputs(8);
  endtask

  task automatic test_memory_backpressure();
    @(negedge clk);
    mem_gap = 5;
    pulse_redirect(TGT_SLOW);
    wait_outputs(24);  // three cold lines
    @(negedge clk);
    mem_gap = 0;
  endtask

  task automatic test_conflict_eviction();
    watch_base = LINE_A;
    watch_hits = 0;
    pulse_redirect(LINE_A);
    wait_outputs(4);
    pulse_redirect(LINE_A + fetch_pkg::pc_t'(fetch_pkg::IC_SETS * 32));  // same set
    wait_outputs(4);
    pulse_redirect(LINE_A);
    wait_outputs(4);
    if (watch_hits < 2) begin
      $display("line A was not fetched from memory again after eviction");
      end_with_failure();
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    test_reset_first_fetch();
    test_sequential_stream();
    test_decode_backpressure();
    test_redirect();
    test_memory_backpressure();
    test_conflict_eviction();
    $display("Test passed");
    $finish;
  end

endmodule

/* files.f */
rtl/fetch_pkg.sv
rtl/pc_gen.sv
rtl/icache.sv
rtl/refill_ctrl.sv
rtl/if_stage.sv
dv/mem_model.sv
dv/tb_if_stage.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_if_stage \
		-f files.f --Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb

clean:
	rm -rf obj_dir
